// File: dv/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic check_clear_write();
	check_value("ram_we_o", ram_we_o, 1);
	check_value("ram_addr_o", ram_addr_o, `TK_RAM_CLEAR_ADDR);
	check_value("ram_wdata_o", ram_wdata_o, 0);
endtask

// starts right at the edge that drops reset
task automatic boot_hold_test();
	int release_edge;
	logic [31:0] rnd;
	// counter top bit plus one edge for the register
	release_edge = (1 << (`TK_POR_COUNT_BITS - 1)) + 1;
	// cpu tries a different write, hold must override it
	cpu_ram_addr_i <= 16'h1234;
	cpu_ram_wdata_i <= 8'hA5;
	cpu_ram_we_i <= 1'b0;
	@(negedge clk_sys);
	check_clear_write();
	check_value("cpu_reset_o", cpu_reset_o, 1);
	for (int n = 1; n < release_edge; n++) begin
		@(negedge clk_sys);
		check_value("por_o", por_o, 1);
	end
	@(negedge clk_sys);
	check_value("por_o", por_o, 0);
	check_value("cpu_reset_o", cpu_reset_o, 1);
	@(negedge clk_sys);
	check_value("cpu_reset_o", cpu_reset_o, 0);
	// released, ram port follows the cpu
	for (int k = 0; k < 4; k++) begin
		rnd = $urandom;
		@(posedge clk_sys);
		cpu_ram_addr_i <= rnd[15:0];
		cpu_ram_wdata_i <= rnd[23:16];
		cpu_ram_we_i <= rnd[24];
		@(negedge clk_sys);
		check_value("ram_addr_o", ram_addr_o, rnd[15:0]);
		check_value("ram_wdata_o", ram_wdata_o, rnd[23:16]);
		check_value("ram_we_o", ram_we_o, rnd[24]);
	end
	// data pump brings the hold back
	@(posedge clk_sys);
	pump_active_i <= 1'b1;
	wait_level(sel_por, 1'b1, 4, "por_o after pump start");
	check_clear_write();
	repeat (3) @(posedge clk_sys);
	pump_active_i <= 1'b0;
	wait_level(sel_por, 1'b0, release_edge + 4, "por_o release after pump");
	check_value("ram_addr_o", ram_addr_o, rnd[15:0]);
endtask

// stick bits: right, left, down, up, fire1, fire2
function automatic logic [5:0] expected_cols(input int row, input int ctrl,
	input logic [5:0] cols);
	logic [5:0] joy;
	joy = '0;
	case (ctrl)
		0: joy[0] = (row == 4);
		1: joy[0] = (row == 3);
		2: joy[0] = (row == 5);
		3: joy[0] = (row == 6);
		4: joy[4] = (row == 7);
		5: joy[5] = (row == 1);
		default: joy = '0;
	endcase
	return cols | joy;
endfunction

task automatic joystick_merge_test();
	logic [31:0] rnd;
	logic [5:0] cols;
	for (int row = 0; row < 8; row++) begin
		for (int ctrl = 0; ctrl < 6; ctrl++) begin
			// zero columns first, so a wrong-row press would show
			for (int pass = 0; pass < 2; pass++) begin
				rnd = $urandom;
				cols = (pass == 0) ? 6'h00 : rnd[5:0];
				@(posedge clk_sys);
				kbd_rows_i <= 8'(1 << row);
				joystick_0_i <= 32'(1 << ctrl);
				kbd_cols_i <= cols;
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_value("kbd_cols_o", kbd_cols_o, expected_cols(row, ctrl, cols));
			end
		end
	end
	@(posedge clk_sys);
	kbd_rows_i <= '0;
	joystick_0_i <= '0;
	kbd_cols_i <= '0;
endtask

task automatic check_hdd_quiet();
	repeat (4) begin
		@(negedge clk_sys);
		check_value("sd_rd_o", sd_rd_o, 0);
		check_value("sd_wr_o", sd_wr_o, 0);
		check_value("cpu_wait_o", cpu_wait_o, 0);
	end
endtask

// sd host side of one transfer, strobe already up
task automatic finish_transfer();
	@(posedge clk_sys);
	sd_ack_i <= 1'b1;
	wait_level(sel_sd_rd, 1'b0, 10, "sd_rd_o to drop after ack");
	check_value("sd_wr_o", sd_wr_o, 0);
	check_value("cpu_wait_o", cpu_wait_o, 1);
	@(posedge clk_sys);
	sd_ack_i <= 1'b0;
	wait_level(sel_cpu_wait, 1'b0, 10, "cpu_wait_o release");
	check_hdd_quiet();
endtask

task automatic hdd_read_test();
	logic [31:0] rnd;
	logic [`TK_LBA_W-1:0] lba_exp;
	rnd = $urandom;
	lba_exp = '0;
	lba_exp[`TK_SECTOR_W-1:0] = rnd[`TK_SECTOR_W-1:0];
	@(posedge clk_sys);
	hdd_sector_i <= rnd[`TK_SECTOR_W-1:0];
	hdd_read_i <= 1'b1;
	@(posedge clk_sys);
	hdd_read_i <= 1'b0;
	wait_level(sel_sd_rd, 1'b1, 10, "sd_rd_o to rise");
	check_value("cpu_wait_o", cpu_wait_o, 1);
	check_value("sd_wr_o", sd_wr_o, 0);
	check_value("sd_lba_o", sd_lba_o, lba_exp);
	finish_transfer();
endtask

task automatic hdd_write_backpressure_test();
	@(posedge clk_sys);
	hdd_write_i <= 1'b1;
	@(posedge clk_sys);
	hdd_write_i <= 1'b0;
	wait_level(sel_sd_wr, 1'b1, 10, "sd_wr_o to rise");
	// no ack, strobe and stall must hold
	// a read arriving now joins the open request
	for (int i = 0; i < 50; i++) begin
		@(posedge clk_sys);
		hdd_read_i <= (i == 10);
		@(negedge clk_sys);
		check_value("sd_wr_o", sd_wr_o, 1);
		check_value("cpu_wait_o", cpu_wait_o, 1);
	end
	check_value("sd_rd_o", sd_rd_o, 1);
	finish_transfer();
endtask

task automatic mount_slot(input int slot, input logic [63:0] size, input logic readonly);
	@(posedge clk_sys);
	img_mounted_i <= 3'(1 << slot);
	img_size_i <= size;
	img_readonly_i <= readonly;
	@(posedge clk_sys);
	img_mounted_i <= 3'b000;
	@(negedge clk_sys);
endtask

task automatic image_mount_test();
	logic [31:0] rnd;
	logic [63:0] size;
	logic change_exp;
	rnd = $urandom;
	size = {rnd, rnd | 32'h1};
	mount_slot(`TK_SLOT_HDD, size, 1'b1);
	check_value("hdd_mounted_o", hdd_mounted_o, 1);
	check_value("hdd_protect_o", hdd_protect_o, 1);
	check_value("fd_change_o", fd_change_o, 0);
	check_value("fd_mounted_o", fd_mounted_o, 0);
	// each floppy mount flips the change bit
	change_exp = 1'b0;
	for (int k = 0; k < 2; k++) begin
		mount_slot(`TK_SLOT_FDD_A, size, 1'b0);
		change_exp = ~change_exp;
		check_value("fd_change_o", fd_change_o, {1'b0, change_exp});
		check_value("fd_mounted_o", fd_mounted_o, 2'b01);
	end
	// eject, zero size
	mount_slot(`TK_SLOT_FDD_A, 64'h0, 1'b0);
	change_exp = ~change_exp;
	check_value("fd_mounted_o", fd_mounted_o, 2'b00);
	check_value("fd_change_o", fd_change_o, {1'b0, change_exp});
	check_value("hdd_mounted_o", hdd_mounted_o, 1);
	check_value("hdd_protect_o", hdd_protect_o, 1);
endtask

`endif

// File: dv/tb_top.sv
`include "tk2000_settings.svh"

module tb_top;

	// 8 unit clock
	localparam int half_period = 4;
	localparam int reset_cycles = 5;

	// selectors for the level wait helper
	localparam int sel_por = 0;
	localparam int sel_sd_rd = 1;
	localparam int sel_sd_wr = 2;
	localparam int sel_cpu_wait = 3;

	logic clk_sys;
	logic reset;
	logic pump_active_i;
	logic [`TK_RAM_ADDR_W-1:0] cpu_ram_addr_i;
	logic [`TK_DATA_W-1:0] cpu_ram_wdata_i;
	logic cpu_ram_we_i;
	logic [`TK_RAM_ADDR_W-1:0] ram_addr_o;
	logic [`TK_DATA_W-1:0] ram_wdata_o;
	logic ram_we_o;
	logic por_o;
	logic cpu_reset_o;
	logic [`TK_DATA_W-1:0] kbd_rows_i;
	logic [`TK_KBD_COLS_W-1:0] kbd_cols_i;
	logic [`TK_JOY_W-1:0] joystick_0_i;
	logic [`TK_KBD_COLS_W-1:0] kbd_cols_o;
	logic [`TK_SECTOR_W-1:0] hdd_sector_i;
	logic hdd_read_i;
	logic hdd_write_i;
	logic sd_ack_i;
	logic [`TK_LBA_W-1:0] sd_lba_o;
	logic sd_rd_o;
	logic sd_wr_o;
	logic cpu_wait_o;
	logic [2:0] img_mounted_i;
	logic [63:0] img_size_i;
	logic img_readonly_i;
	logic hdd_mounted_o;
	logic hdd_protect_o;
	logic [1:0] fd_mounted_o;
	logic [1:0] fd_change_o;

	tk2000_glue dut_i (.*);

	// first error ends the run
	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// single bit dut outputs the waits can poll
	function automatic logic probe(input int sel);
		case (sel)
			sel_por: return por_o;
			sel_sd_rd: return sd_rd_o;
			sel_sd_wr: return sd_wr_o;
			sel_cpu_wait: return cpu_wait_o;
			default: return 1'bx;
		endcase
	endfunction

	// polls at falling edges away from the drive edge
	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (probe(sel) !== level && waited < limit) begin
			@(negedge clk_sys);
			waited++;
		end
		if (probe(sel) !== level) begin
			stop_on_error({"timeout while waiting for ", what});
		end
	endtask

	`include "tb_tests.svh"

	initial begin
		clk_sys = 1'b0;
		forever #half_period clk_sys = ~clk_sys;
	end

	initial begin
		void'($urandom(13));
		reset = 1'b1;
		pump_active_i = 1'b0;
		cpu_ram_addr_i = '0;
		cpu_ram_wdata_i = '0;
		cpu_ram_we_i = 1'b0;
		kbd_rows_i = '0;
		kbd_cols_i = '0;
		joystick_0_i = '0;
		hdd_sector_i = '0;
		hdd_read_i = 1'b0;
		hdd_write_i = 1'b0;
		sd_ack_i = 1'b0;
		img_mounted_i = '0;
		img_size_i = '0;
		img_readonly_i = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		reset <= 1'b0;
		boot_hold_test();
		joystick_merge_test();
		hdd_read_test();
		hdd_write_backpressure_test();
		image_mount_test();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: logic/boot_reset.sv
`include "tk2000_settings.svh"

module boot_reset
	import tk2000_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      pump_active_i,
	input  ram_addr_t cpu_ram_addr_i,
	input  byte_t     cpu_ram_wdata_i,
	input  logic      cpu_ram_we_i,
	output ram_addr_t ram_addr_o,
	output byte_t     ram_wdata_o,
	output logic      ram_we_o,
	output logic      por_o,
	output logic      cpu_reset_o
);

	// msb of the hold counter ends the stretch
	localparam int unsigned hold_top = `TK_POR_COUNT_BITS - 1;

	logic [`TK_POR_COUNT_BITS-1:0] hold_cnt;

	// stretched reset
	// any cold reset or active data pump restarts the count
	always_ff @(posedge clk_sys) begin
		if (reset || pump_active_i) begin
			por_o <= 1'b1;
			hold_cnt <= '0;
		end else begin
			// released one edge after msb comes up
			if (hold_cnt[hold_top]) begin
				por_o <= 1'b0;
			end
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// cpu reset trails the stretcher by one clock
	// cold reset also reaches the cpu directly
	always_ff @(posedge clk_sys) begin
		cpu_reset_o <= por_o | reset;
	end

	// ram port steering
	// during the hold the boot flag gets zeroed every cycle
	// so the rom takes the cold start path once released
	always_comb begin
		if (por_o) begin
			ram_we_o = 1'b1;
			ram_addr_o = `TK_RAM_CLEAR_ADDR;
			ram_wdata_o = '0;
		end else begin
			ram_we_o = cpu_ram_we_i;
			ram_addr_o = cpu_ram_addr_i;
			ram_wdata_o = cpu_ram_wdata_i;
		end
	end

	// hold always comes with the boot flag clear write
	a_clear_during_hold: assert property (
		@(posedge clk_sys) disable iff (reset)
		por_o |-> (ram_we_o && ram_addr_o == `TK_RAM_CLEAR_ADDR && ram_wdata_o == '0)
	);

endmodule

// File: logic/hdd_request.sv
`include "tk2000_settings.svh"

module hdd_request
	import tk2000_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  sector_t hdd_sector_i,
	input  logic    hdd_read_i,
	input  logic    hdd_write_i,
	input  logic    sd_ack_i,
	output lba_t    sd_lba_o,
	output logic    sd_rd_o,
	output logic    sd_wr_o,
	output logic    cpu_wait_o
);

	hdd_state_e state;
	logic ack_q;
	logic ack_rise;
	logic ack_fall;
	logic rd_pend;
	logic wr_pend;

	// sector maps one to one onto sd blocks
	assign sd_lba_o = {{(`TK_LBA_W - `TK_SECTOR_W){1'b0}}, hdd_sector_i};

	// ack edges against last clock's sample
	assign ack_rise = sd_ack_i & ~ack_q;
	assign ack_fall = ~sd_ack_i & ack_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sd_ack_i;
		end
	end

	// request handshake with the sd host
	// strobe up, ack rises, strobe down, ack falls, cpu released
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= hdd_idle;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
			sd_rd_o <= 1'b0;
			sd_wr_o <= 1'b0;
			cpu_wait_o <= 1'b0;
		end else begin
			// cpu pulses are sticky until the host takes them
			rd_pend <= rd_pend | hdd_read_i;
			wr_pend <= wr_pend | hdd_write_i;

			case (state)
				hdd_idle: begin
					if (rd_pend || wr_pend) begin
						state <= hdd_busy;
						sd_rd_o <= rd_pend;
						sd_wr_o <= wr_pend;
						cpu_wait_o <= 1'b1;
					end
				end
				hdd_busy: begin
					if (ack_rise) begin
						// host took the request
						// a pulse landing right now waits for next transfer
						rd_pend <= hdd_read_i;
						wr_pend <= hdd_write_i;
						sd_rd_o <= 1'b0;
						sd_wr_o <= 1'b0;
					end else if (ack_fall) begin
						// block moved, cpu may run again
						state <= hdd_idle;
						cpu_wait_o <= 1'b0;
					end else if (sd_rd_o || sd_wr_o) begin
						// not yet acked, late requests join in
						sd_rd_o <= rd_pend;
						sd_wr_o <= wr_pend;
					end
				end
				default: begin
					state <= hdd_idle;
				end
			endcase
		end
	end

	// cpu stalled whenever a strobe is out
	a_strobe_stalls_cpu: assert property (
		@(posedge clk_sys) disable iff (reset)
		(sd_rd_o || sd_wr_o) |-> cpu_wait_o
	);

	// strobes come only from a pending flag,
	// either leaving idle or joining a transfer not yet acked
	a_rd_rise_source: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd_o) |-> $past(rd_pend && (state == hdd_idle || sd_wr_o))
	);

	a_wr_rise_source: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(sd_wr_o) |-> $past(wr_pend && (state == hdd_idle || sd_rd_o))
	);

endmodule

// File: logic/image_mount_monitor.sv
`include "tk2000_settings.svh"

module image_mount_monitor (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [2:0]  img_mounted_i,
	input  logic [63:0] img_size_i,
	input  logic        img_readonly_i,
	output logic        hdd_mounted_o,
	output logic        hdd_protect_o,
	output logic [1:0]  fd_mounted_o,
	output logic [1:0]  fd_change_o
);

	logic img_present;
	logic [1:0] fdd_strobe;

	// zero size means the host ejected the image
	assign img_present = |img_size_i;

	// floppy strobes packed in drive order
	assign fdd_strobe = {img_mounted_i[`TK_SLOT_FDD_B], img_mounted_i[`TK_SLOT_FDD_A]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd_mounted_o <= 1'b0;
			hdd_protect_o <= 1'b0;
			fd_mounted_o <= '0;
			fd_change_o <= '0;
		end else begin
			// hard disk keeps the host's write protect flag
			if (img_mounted_i[`TK_SLOT_HDD]) begin
				hdd_mounted_o <= img_present;
				hdd_protect_o <= img_readonly_i;
			end
			// floppies flip a change bit on every mount event,
			// the drive side reloads its track on any edge
			for (int i = 0; i < 2; i++) begin
				if (fdd_strobe[i]) begin
					fd_mounted_o[i] <= img_present;
					fd_change_o[i] <= ~fd_change_o[i];
				end
			end
		end
	end

endmodule

// File: logic/joy_key_merge.sv
module joy_key_merge
	import tk2000_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  byte_t     kbd_rows_i,
	input  kbd_cols_t kbd_cols_i,
	input  joy_word_u joystick_i,
	output kbd_cols_t kbd_cols_o
);

	// keyboard rows holding the keys the stick stands in for
	// arrows share column 0 on four rows
	localparam int unsigned row_up    = 6;
	localparam int unsigned row_down  = 5;
	localparam int unsigned row_right = 4;
	localparam int unsigned row_left  = 3;
	// fire buttons map to the . and L keys
	localparam int unsigned row_fire1 = 7;
	localparam int unsigned row_fire2 = 1;

	// column bits of those keys
	localparam int unsigned col_arrow = 0;
	localparam int unsigned col_fire1 = 4;
	localparam int unsigned col_fire2 = 5;

	kbd_cols_t joy_cols;
	logic arrow_hit;

	// an arrow only shows up while its own row is scanned
	assign arrow_hit = (kbd_rows_i[row_up]    & joystick_i.fields.up)
		| (kbd_rows_i[row_down]  & joystick_i.fields.down)
		| (kbd_rows_i[row_right] & joystick_i.fields.right)
		| (kbd_rows_i[row_left]  & joystick_i.fields.left);

	// columns the joystick would press in the current scan
	always_comb begin
		joy_cols = '0;
		joy_cols[col_arrow] = arrow_hit;
		joy_cols[col_fire1] = kbd_rows_i[row_fire1] & joystick_i.fields.fire1;
		joy_cols[col_fire2] = kbd_rows_i[row_fire2] & joystick_i.fields.fire2;
	end

	// real keys and stick merged, one clock late
	// the cpu samples columns well after driving a row
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kbd_cols_o <= '0;
		end else begin
			kbd_cols_o <= kbd_cols_i | joy_cols;
		end
	end

endmodule

// File: logic/tk2000_glue.sv
`include "tk2000_settings.svh"

module tk2000_glue (
	input  logic                      clk_sys,
	input  logic                      reset,

	// boot hold and cpu ram port
	input  logic                      pump_active_i,
	input  logic [`TK_RAM_ADDR_W-1:0] cpu_ram_addr_i,
	input  logic [`TK_DATA_W-1:0]     cpu_ram_wdata_i,
	input  logic                      cpu_ram_we_i,
	output logic [`TK_RAM_ADDR_W-1:0] ram_addr_o,
	output logic [`TK_DATA_W-1:0]     ram_wdata_o,
	output logic                      ram_we_o,
	output logic                      por_o,
	output logic                      cpu_reset_o,

	// keyboard scan and joystick
	input  logic [`TK_DATA_W-1:0]     kbd_rows_i,
	input  logic [`TK_KBD_COLS_W-1:0] kbd_cols_i,
	input  logic [`TK_JOY_W-1:0]      joystick_0_i,
	output logic [`TK_KBD_COLS_W-1:0] kbd_cols_o,

	// hard disk requests and sd slot
	input  logic [`TK_SECTOR_W-1:0]   hdd_sector_i,
	input  logic                      hdd_read_i,
	input  logic                      hdd_write_i,
	input  logic                      sd_ack_i,
	output logic [`TK_LBA_W-1:0]      sd_lba_o,
	output logic                      sd_rd_o,
	output logic                      sd_wr_o,
	output logic                      cpu_wait_o,

	// host image mounts
	input  logic [2:0]                img_mounted_i,
	input  logic [63:0]               img_size_i,
	input  logic                      img_readonly_i,
	output logic                      hdd_mounted_o,
	output logic                      hdd_protect_o,
	output logic [1:0]                fd_mounted_o,
	output logic [1:0]                fd_change_o
);

	// reset stretcher in front of the cpu ram port
	boot_reset boot_reset_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pump_active_i   (pump_active_i),
		.cpu_ram_addr_i  (cpu_ram_addr_i),
		.cpu_ram_wdata_i (cpu_ram_wdata_i),
		.cpu_ram_we_i    (cpu_ram_we_i),
		.ram_addr_o      (ram_addr_o),
		.ram_wdata_o     (ram_wdata_o),
		.ram_we_o        (ram_we_o),
		.por_o           (por_o),
		.cpu_reset_o     (cpu_reset_o)
	);

	// raw host word lands on the union port
	joy_key_merge joy_key_merge_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.joystick_i (joystick_0_i),
		.kbd_cols_o (kbd_cols_o)
	);

	// hard disk slot of the sd host
	hdd_request hdd_request_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.hdd_sector_i (hdd_sector_i),
		.hdd_read_i   (hdd_read_i),
		.hdd_write_i  (hdd_write_i),
		.sd_ack_i     (sd_ack_i),
		.sd_lba_o     (sd_lba_o),
		.sd_rd_o      (sd_rd_o),
		.sd_wr_o      (sd_wr_o),
		.cpu_wait_o   (cpu_wait_o)
	);

	image_mount_monitor image_mount_monitor_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.img_mounted_i  (img_mounted_i),
		.img_size_i     (img_size_i),
		.img_readonly_i (img_readonly_i),
		.hdd_mounted_o  (hdd_mounted_o),
		.hdd_protect_o  (hdd_protect_o),
		.fd_mounted_o   (fd_mounted_o),
		.fd_change_o    (fd_change_o)
	);

endmodule

// File: logic/tk2000_pkg.sv
`include "tk2000_settings.svh"

package tk2000_pkg;

	// basic bus words
	typedef logic [`TK_DATA_W-1:0] byte_t;
	typedef logic [`TK_RAM_ADDR_W-1:0] ram_addr_t;

	// one keyboard column sample, bit set means key down
	typedef logic [`TK_KBD_COLS_W-1:0] kbd_cols_t;

	// hard disk sector number from the cpu side
	typedef logic [`TK_SECTOR_W-1:0] sector_t;

	// block address as seen by the sd host
	typedef logic [`TK_LBA_W-1:0] lba_t;

	// joystick controls, all active high
	// right sits in bit 0
	typedef struct packed {
		logic [`TK_JOY_W-7:0] reserved;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_fields_t;

	// same 32 bit word, raw from the host or split into controls
	typedef union packed {
		logic [`TK_JOY_W-1:0] raw;
		joy_fields_t fields;
	} joy_word_u;

	// hard disk sequencer
	// busy covers request, ack high and ack low phases
	typedef enum logic {
		hdd_idle = 1'b0,
		hdd_busy = 1'b1
	} hdd_state_e;

endpackage

// File: logic/tk2000_settings.svh
`ifndef TK2000_SETTINGS_SVH
`define TK2000_SETTINGS_SVH

// cpu data bus and ram address widths
`define TK_DATA_W 8
`define TK_RAM_ADDR_W 16

// reset hold counter width
// 6 keeps simulation short, hardware build uses 23
`define TK_POR_COUNT_BITS 6

// boot flag location, zeroed while reset is held
`define TK_RAM_CLEAR_ADDR 16'h3F4

// hard disk sector and sd block address widths
`define TK_SECTOR_W 16
`define TK_LBA_W 32

// keyboard column word and raw joystick word
`define TK_KBD_COLS_W 6
`define TK_JOY_W 32

// positions in the image mounted strobe vector
`define TK_SLOT_FDD_A 0
`define TK_SLOT_HDD 1
`define TK_SLOT_FDD_B 2

`endif

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module tb_top \
	--Mdir obj_dir \
	-o tb_top_sim

# the simulator exits nonzero on $fatal, the log decides the result
./obj_dir/tb_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if ! grep -q "Everything OK" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0

// File: sim.f
+incdir+logic
+incdir+dv
logic/tk2000_pkg.sv
logic/boot_reset.sv
logic/joy_key_merge.sv
logic/hdd_request.sv
logic/image_mount_monitor.sv
logic/tk2000_glue.sv
dv/tb_top.sv
